// File: verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int pc_width = 10;
	localparam int data_width = 32;
	localparam int reg_addr_width = 5;
	localparam int imm_width = 14;
	localparam int dmem_addr_width = 8;

	// Instruction word, msb first.
	//   [31:26] opcode
	//   [25:21] rt, destination or store source
	//   [20:16] ra, first source
	//   [15:11] rb, second source
	//   [13:0]  imm14, shares bits with rb on immediate forms
	typedef enum logic [5:0] {
		op_nop  = 6'd0,
		op_add  = 6'd1,
		op_sub  = 6'd2,
		op_and  = 6'd3,
		op_or   = 6'd4,
		op_xor  = 6'd5,
		op_addi = 6'd6,
		op_lw   = 6'd7,
		op_sw   = 6'd8,
		op_beq  = 6'd9
	} opcode_e;

	typedef struct packed {
		logic [data_width-1:0] instr;
		logic [pc_width-1:0]   pc_next;
	} if_id_t;

	typedef struct packed {
		opcode_e                   opcode;
		logic [data_width-1:0]     ra_data;
		logic [data_width-1:0]     rb_data;
		logic [data_width-1:0]     imm;
		logic [reg_addr_width-1:0] rd;
		logic [pc_width-1:0]       pc_next;
		logic                      do_dm_read;
		logic                      do_dm_write;
		logic                      do_reg_write;
		logic                      is_branch;
	} id_ex_t;

	typedef struct packed {
		logic [data_width-1:0]     result;
		logic                      overflow;
		logic [data_width-1:0]     store_data;
		logic [reg_addr_width-1:0] rd;
		logic                      do_dm_read;
		logic                      do_dm_write;
		logic                      do_reg_write;
	} ex_mem_t;

	typedef struct packed {
		logic                      do_reg_write;
		logic [reg_addr_width-1:0] addr;
		logic [data_width-1:0]     data;
	} mem_wb_t;

endpackage

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input wire cpu_pkg::id_ex_t stage,
	output logic [cpu_pkg::data_width-1:0] result,
	output logic overflow,
	output logic branch_taken
);
	import cpu_pkg::*;

	logic [data_width-1:0] a;
	logic [data_width-1:0] b;
	logic [data_width-1:0] sum;
	logic [data_width-1:0] diff;

	assign a = stage.ra_data;
	assign b = (stage.opcode inside {op_addi, op_lw, op_sw}) ? stage.imm : stage.rb_data;
	assign sum = a + b;
	assign diff = a - b;

	always_comb begin
		result = '0;
		overflow = 1'b0;
		case (stage.opcode)
			op_add, op_addi: begin
				result = sum;
				overflow = (a[data_width-1] == b[data_width-1])
					&& (sum[data_width-1] != a[data_width-1]);
			end
			op_sub: begin
				result = diff;
				overflow = (a[data_width-1] != b[data_width-1])
					&& (diff[data_width-1] != a[data_width-1]);
			end
			op_and: result = a & b;
			op_or: result = a | b;
			op_xor: result = a ^ b;
			// Effective address, never flagged.
			op_lw, op_sw: result = sum;
			default: result = '0;
		endcase
	end

	assign branch_taken = stage.is_branch && (a == stage.rb_data);

endmodule

`default_nettype wire

// File: verilog/data_memory.sv
`timescale 1ns/1ps
`default_nettype none

module data_memory (
	input wire clock,
	input wire [cpu_pkg::dmem_addr_width-1:0] addr,
	input wire [cpu_pkg::data_width-1:0] wdata,
	input wire write,
	output logic [cpu_pkg::data_width-1:0] rdata
);
	import cpu_pkg::*;

	logic [data_width-1:0] mem [2**dmem_addr_width];

	always_ff @(posedge clock) begin
		if (write) begin
			mem[addr] <= wdata;
		end
	end

	// Asynchronous read port.
	assign rdata = mem[addr];

endmodule

`default_nettype wire

// File: verilog/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
	input wire [cpu_pkg::reg_addr_width-1:0] ra_addr,
	input wire [cpu_pkg::reg_addr_width-1:0] rb_addr,
	input wire uses_rb,
	input wire cpu_pkg::id_ex_t id_stage,
	input wire cpu_pkg::ex_mem_t ex_stage,
	input wire cpu_pkg::mem_wb_t wb_stage,
	input wire branch_taken,
	output logic stall,
	output logic flush_fetch,
	output logic flush_decode
);
	import cpu_pkg::*;

	logic raw;

	function automatic logic depends(input logic writes, input logic [reg_addr_width-1:0] dest);
		return writes && dest != '0
			&& (dest == ra_addr || (uses_rb && dest == rb_addr));
	endfunction

	always_comb begin
		raw = depends(id_stage.do_reg_write, id_stage.rd)
			|| depends(ex_stage.do_reg_write, ex_stage.rd)
			|| depends(wb_stage.do_reg_write, wb_stage.addr);
	end

	// The stalled instruction is flushed anyway.
	assign stall = raw && !branch_taken;
	assign flush_fetch = branch_taken;
	assign flush_decode = branch_taken;

endmodule

`default_nettype wire

// File: verilog/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
	input wire [cpu_pkg::data_width-1:0] instr,
	input wire [cpu_pkg::pc_width-1:0] pc_next,
	input wire [cpu_pkg::data_width-1:0] ra_data,
	input wire [cpu_pkg::data_width-1:0] rb_data,
	output logic [cpu_pkg::reg_addr_width-1:0] ra_addr,
	output logic [cpu_pkg::reg_addr_width-1:0] rb_addr,
	output logic uses_rb,
	output cpu_pkg::id_ex_t decoded
);
	import cpu_pkg::*;

	opcode_e op;
	logic [reg_addr_width-1:0] rt;
	logic [data_width-1:0] imm_ext;

	assign op = opcode_e'(instr[31:26]);
	assign rt = instr[25:21];
	assign ra_addr = instr[20:16];

	// Stores and branches read their second operand through rt.
	assign rb_addr = (op == op_sw || op == op_beq) ? rt : instr[15:11];
	assign uses_rb = op inside {op_add, op_sub, op_and, op_or, op_xor, op_sw, op_beq};

	assign imm_ext = {{(data_width - imm_width){instr[imm_width-1]}}, instr[imm_width-1:0]};

	always_comb begin
		decoded = '0;
		decoded.opcode = op;
		decoded.ra_data = ra_data;
		decoded.rb_data = rb_data;
		decoded.imm = imm_ext;
		decoded.rd = rt;
		decoded.pc_next = pc_next;
		case (op)
			op_add, op_sub, op_and, op_or, op_xor, op_addi: begin
				decoded.do_reg_write = (rt != '0);
			end
			op_lw: begin
				decoded.do_dm_read = 1'b1;
				decoded.do_reg_write = (rt != '0);
			end
			op_sw: begin
				decoded.do_dm_write = 1'b1;
			end
			op_beq: begin
				decoded.is_branch = 1'b1;
			end
			// NOP and unused codes do nothing.
			default: begin
				decoded.opcode = op_nop;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input wire clock,
	input wire rst_n,
	input wire [cpu_pkg::reg_addr_width-1:0] ra_addr,
	input wire [cpu_pkg::reg_addr_width-1:0] rb_addr,
	output logic [cpu_pkg::data_width-1:0] ra_data,
	output logic [cpu_pkg::data_width-1:0] rb_data,
	input wire cpu_pkg::mem_wb_t wr
);
	import cpu_pkg::*;

	logic [data_width-1:0] regs [2**reg_addr_width];

	// Same-cycle write is visible to the reader.
	function automatic logic [data_width-1:0] read_port(input logic [reg_addr_width-1:0] addr);
		if (addr == '0) begin
			return '0;
		end
		if (wr.do_reg_write && wr.addr == addr) begin
			return wr.data;
		end
		return regs[addr];
	endfunction

	always_comb begin
		ra_data = read_port(ra_addr);
		rb_data = read_port(rb_addr);
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**reg_addr_width; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.do_reg_write && wr.addr != '0) begin
			regs[wr.addr] <= wr.data;
		end
	end

endmodule

`default_nettype wire

// File: verilog/pipeline_walls.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_walls (
	input wire clock,
	input wire rst_n,
	input wire stall,
	input wire flush_fetch,
	input wire flush_decode,
	input wire cpu_pkg::if_id_t if_in,
	input wire cpu_pkg::id_ex_t id_in,
	input wire cpu_pkg::ex_mem_t ex_in,
	input wire cpu_pkg::mem_wb_t mem_in,
	output cpu_pkg::if_id_t if_out,
	output cpu_pkg::id_ex_t id_out,
	output cpu_pkg::ex_mem_t ex_out,
	output cpu_pkg::mem_wb_t mem_out
);

	// Fetch wall. A flush wins over a stall.
	always_ff @(posedge clock) begin
		if (!rst_n || flush_fetch) begin
			if_out <= '0;
		end else if (!stall) begin
			if_out <= if_in;
		end
	end

	// Decode wall takes a bubble while fetch is held.
	always_ff @(posedge clock) begin
		if (!rst_n || flush_decode || stall) begin
			id_out <= '0;
		end else begin
			id_out <= id_in;
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			ex_out <= '0;
		end else begin
			ex_out <= ex_in;
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			mem_out <= '0;
		end else begin
			mem_out <= mem_in;
		end
	end

endmodule

`default_nettype wire

// File: verilog/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
	input wire clock,
	input wire rst_n,
	output logic [cpu_pkg::pc_width-1:0] imem_addr,
	input wire [cpu_pkg::data_width-1:0] imem_data,
	output logic wb_valid,
	output logic [cpu_pkg::reg_addr_width-1:0] wb_addr,
	output logic [cpu_pkg::data_width-1:0] wb_data
);
	import cpu_pkg::*;

	logic [pc_width-1:0] pc;
	logic [pc_width-1:0] pc_plus_one;
	logic [pc_width-1:0] branch_target;

	if_id_t if_in;
	if_id_t if_out;
	id_ex_t id_in;
	id_ex_t id_out;
	ex_mem_t ex_in;
	ex_mem_t ex_out;
	mem_wb_t mem_in;
	mem_wb_t mem_out;

	logic [reg_addr_width-1:0] ra_addr;
	logic [reg_addr_width-1:0] rb_addr;
	logic uses_rb;
	logic [data_width-1:0] ra_data;
	logic [data_width-1:0] rb_data;
	logic [data_width-1:0] alu_result;
	logic alu_overflow;
	logic branch_taken;
	logic stall;
	logic flush_fetch;
	logic flush_decode;
	logic [data_width-1:0] dmem_rdata;

	assign pc_plus_one = pc + 1'b1;
	assign branch_target = id_out.pc_next + id_out.imm[pc_width-1:0];
	assign imem_addr = pc;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (branch_taken) begin
			pc <= branch_target;
		end else if (!stall) begin
			pc <= pc_plus_one;
		end
	end

	assign if_in.instr = imem_data;
	assign if_in.pc_next = pc_plus_one;

	pipeline_walls u_walls (
		.clock(clock), .rst_n(rst_n), .stall(stall),
		.flush_fetch(flush_fetch), .flush_decode(flush_decode),
		.if_in(if_in), .id_in(id_in), .ex_in(ex_in), .mem_in(mem_in),
		.if_out(if_out), .id_out(id_out), .ex_out(ex_out), .mem_out(mem_out)
	);

	instr_decoder u_decoder (
		.instr(if_out.instr), .pc_next(if_out.pc_next),
		.ra_data(ra_data), .rb_data(rb_data),
		.ra_addr(ra_addr), .rb_addr(rb_addr), .uses_rb(uses_rb), .decoded(id_in)
	);

	register_file u_regs (
		.clock(clock), .rst_n(rst_n), .ra_addr(ra_addr), .rb_addr(rb_addr),
		.ra_data(ra_data), .rb_data(rb_data), .wr(mem_out)
	);

	hazard_unit u_hazard (
		.ra_addr(ra_addr), .rb_addr(rb_addr), .uses_rb(uses_rb),
		.id_stage(id_out), .ex_stage(ex_out), .wb_stage(mem_out),
		.branch_taken(branch_taken), .stall(stall),
		.flush_fetch(flush_fetch), .flush_decode(flush_decode)
	);

	alu u_alu (
		.stage(id_out), .result(alu_result),
		.overflow(alu_overflow), .branch_taken(branch_taken)
	);

	always_comb begin
		ex_in.result = alu_result;
		ex_in.overflow = alu_overflow;
		ex_in.store_data = id_out.rb_data;
		ex_in.rd = id_out.rd;
		ex_in.do_dm_read = id_out.do_dm_read;
		ex_in.do_dm_write = id_out.do_dm_write;
		ex_in.do_reg_write = id_out.do_reg_write;
	end

	data_memory u_dmem (
		.clock(clock), .addr(ex_out.result[dmem_addr_width-1:0]),
		.wdata(ex_out.store_data), .write(ex_out.do_dm_write), .rdata(dmem_rdata)
	);

	// Overflowed arithmetic retires without a write.
	always_comb begin
		mem_in.do_reg_write = ex_out.do_reg_write && !ex_out.overflow;
		mem_in.addr = ex_out.rd;
		mem_in.data = ex_out.do_dm_read ? dmem_rdata : ex_out.result;
	end

	assign wb_valid = mem_out.do_reg_write;
	assign wb_addr = mem_out.addr;
	assign wb_data = mem_out.data;

endmodule

`default_nettype wire

// File: dv/cpu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_assertions (
	input wire clock,
	input wire rst_n,
	input wire stall,
	input wire flush_fetch,
	input wire flush_decode,
	input wire [cpu_pkg::pc_width-1:0] pc,
	input wire cpu_pkg::if_id_t if_out,
	input wire [cpu_pkg::pc_width-1:0] imem_addr,
	input wire wb_valid,
	input wire [cpu_pkg::reg_addr_width-1:0] wb_addr,
	input wire [cpu_pkg::data_width-1:0] wb_data
);

	int failures = 0;

	outputs_known: assert property (@(posedge clock) disable iff (!rst_n)
		!$isunknown({imem_addr, wb_valid, wb_addr, wb_data}))
	else begin
		failures++;
		$error("Core output is unknown after reset");
	end

	// A flush clears the fetch wall rather than holding it.
	flush_clears_fetch: assert property (@(posedge clock) disable iff (!rst_n)
		flush_fetch |=> (if_out == '0))
	else begin
		failures++;
		$error("Fetch wall was not cleared after a flush");
	end

	pc_holds_on_stall: assert property (@(posedge clock) disable iff (!rst_n)
		stall |=> $stable(pc))
	else begin
		failures++;
		$error("Program counter moved during a stall");
	end

endmodule

bind cpu_core cpu_assertions assert_checks (
	.clock(clock), .rst_n(rst_n), .stall(stall), .flush_fetch(flush_fetch),
	.flush_decode(flush_decode), .pc(pc), .if_out(if_out), .imem_addr(imem_addr),
	.wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data)
);

`default_nettype wire

// File: dv/cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
	input wire clock,
	input wire rst_n,
	input wire wb_valid,
	input wire [cpu_pkg::reg_addr_width-1:0] wb_addr,
	input wire [cpu_pkg::data_width-1:0] wb_data
);
	import cpu_pkg::*;

	typedef struct packed {
		logic [reg_addr_width-1:0] addr;
		logic [data_width-1:0] data;
	} write_t;

	write_t expected [$];
	int errors = 0;
	int checked = 0;

	task automatic start_test();
		expected.delete();
		errors = 0;
		checked = 0;
	endtask

	task automatic expect_write(input logic [reg_addr_width-1:0] addr,
		input logic [data_width-1:0] data);
		expected.push_back({addr, data});
	endtask

	function automatic int pending_writes();
		return expected.size();
	endfunction

	// Sampled on the falling edge, away from the write-back wall update.
	always @(negedge clock) begin
		write_t want;
		if (rst_n && wb_valid) begin
			if (expected.size() == 0) begin
				$display("At %0t register %0d was written with %h although no write was due",
					$time, wb_addr, wb_data);
				errors++;
			end else begin
				want = expected.pop_front();
				checked++;
				if (wb_addr !== want.addr) begin
					$display("Mismatch at %0t: wb_addr expected %0d, got %0d",
						$time, want.addr, wb_addr);
					errors++;
				end
				if (wb_data !== want.data) begin
					$display("Mismatch at %0t: wb_data expected %h, got %h",
						$time, want.data, wb_data);
					errors++;
				end
			end
		end
	end

	task automatic finish_test(input int test_num, output int test_errors);
		if (expected.size() != 0) begin
			$display("Test %0d timed out with %0d expected writes never seen",
				test_num, expected.size());
			errors++;
		end
		$display("Test %0d: %0d writes checked, %0d errors, %s",
			test_num, checked, errors, (errors == 0) ? "pass" : "fail");
		test_errors = errors;
	endtask

endmodule

`default_nettype wire

// File: dv/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
	import cpu_pkg::*;

	localparam int num_tests = 4;
	localparam int body_len = 40;
	localparam int wait_limit = 4000;

	logic clock = 1'b0;
	logic rst_n;
	logic [pc_width-1:0] imem_addr;
	logic [data_width-1:0] imem_data;
	logic wb_valid;
	logic [reg_addr_width-1:0] wb_addr;
	logic [data_width-1:0] wb_data;

	logic [data_width-1:0] imem [2**pc_width];
	int prog_len;
	logic [31:0] rng_state = 32'd10535;
	int passed_tests = 0;
	int failed_tests = 0;

	always #4 clock = ~clock;

	// Instruction memory answers in the same cycle.
	assign imem_data = imem[imem_addr];

	cpu_core uut (
		.clock(clock), .rst_n(rst_n), .imem_addr(imem_addr), .imem_data(imem_data),
		.wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data)
	);

	cpu_checker chk (
		.clock(clock), .rst_n(rst_n), .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data)
	);

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic int pick_reg();
		return next_random() % 8;
	endfunction

	function automatic logic [31:0] encode(opcode_e op, int rt, int ra, int rb, int imm);
		return {op, rt[4:0], ra[4:0], rb[4:0], 11'd0} | {18'd0, imm[13:0]};
	endfunction

	task automatic emit(input logic [31:0] word);
		imem[prog_len] = word;
		prog_len++;
	endtask

	task automatic build_program();
		int kind;
		int a;
		int d;
		for (int i = 0; i < 2**pc_width; i++) begin
			imem[i] = '0;
		end
		prog_len = 0;
		// Registers 1 to 8 seed data words 0 to 7.
		for (int k = 1; k <= 8; k++) begin
			emit(encode(op_addi, k, 0, 0, next_random()));
		end
		for (int k = 1; k <= 8; k++) begin
			emit(encode(op_sw, k, 0, 0, k - 1));
		end
		// Doubling -8192 eighteen times lands exactly on the most negative word.
		emit(encode(op_addi, 9, 0, 0, -8192));
		repeat (18) emit(encode(op_add, 9, 9, 9, 0));
		emit(encode(op_add, 10, 9, 9, 0));
		emit(encode(op_sub, 11, 0, 9, 0));
		emit(encode(op_addi, 12, 9, 0, -1));
		emit(encode(op_xor, 13, 9, 1, 0));
		for (int i = 0; i < body_len; i++) begin
			kind = next_random() % 8;
			case (kind)
				0, 1, 2, 3, 4: begin
					emit(encode(opcode_e'(kind + 1), pick_reg(), pick_reg(), pick_reg(), 0));
				end
				5: emit(encode(op_addi, pick_reg(), pick_reg(), 0, next_random()));
				6: begin
					a = next_random() % 8;
					d = 1 + next_random() % 7;
					emit(encode(op_sw, pick_reg(), 0, 0, a));
					emit(encode(op_lw, d, 0, 0, a));
					emit(encode(op_add, pick_reg(), d, pick_reg(), 0));
				end
				default: begin
					a = pick_reg();
					d = (next_random() % 2 == 0) ? a : pick_reg();
					emit(encode(op_beq, d, a, 0, next_random() % 4));
				end
			endcase
		end
	endtask

	// Instruction-level model of the ISA.
	task automatic run_model();
		logic [31:0] regs [32];
		logic [31:0] dmem [256];
		logic [31:0] word;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] res;
		longint wide;
		opcode_e op;
		int pc;
		int rt;
		logic write;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		pc = 0;
		while (pc < prog_len) begin
			word = imem[pc];
			op = opcode_e'(word[31:26]);
			rt = word[25:21];
			imm = {{18{word[13]}}, word[13:0]};
			a = regs[word[20:16]];
			b = (op inside {op_sw, op_beq}) ? regs[rt] : regs[word[15:11]];
			write = 1'b1;
			res = '0;
			pc++;
			case (op)
				op_add: wide = longint'(signed'(a)) + longint'(signed'(b));
				op_sub: wide = longint'(signed'(a)) - longint'(signed'(b));
				op_addi: wide = longint'(signed'(a)) + longint'(signed'(imm));
				op_and: wide = longint'(a & b);
				op_or: wide = longint'(a | b);
				op_xor: wide = longint'(a ^ b);
				op_lw: wide = longint'(dmem[8'(a + imm)]);
				op_sw: begin
					dmem[8'(a + imm)] = b;
					write = 1'b0;
				end
				op_beq: begin
					if (a == b) begin
						pc = pc + int'(signed'(imm));
					end
					write = 1'b0;
				end
				default: write = 1'b0;
			endcase
			res = wide[31:0];
			if (op inside {op_add, op_sub, op_addi} && wide != longint'(signed'(res))) begin
				write = 1'b0;
			end
			if (write && rt != 0) begin
				regs[rt] = res;
				chk.expect_write(rt[4:0], res);
			end
		end
	endtask

	initial begin
		int errors;
		rst_n <= 1'b0;
		for (int t = 1; t <= num_tests; t++) begin
			rst_n <= 1'b0;
			@(posedge clock);
			build_program();
			chk.start_test();
			run_model();
			repeat (4) @(posedge clock);
			rst_n <= 1'b1;
			for (int n = 0; n < wait_limit && chk.pending_writes() > 0; n++) begin
				@(posedge clock);
			end
			// Longer than the pipeline, so a stray write still shows.
			repeat (8) @(posedge clock);
			chk.finish_test(t, errors);
			if (errors == 0) begin
				passed_tests++;
			end else begin
				failed_tests++;
			end
		end
		$display("Tests run: %0d, passed: %0d, failed: %0d",
			num_tests, passed_tests, failed_tests);
		if (failed_tests == 0 && uut.assert_checks.failures == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/data_memory.sv
verilog/hazard_unit.sv
verilog/instr_decoder.sv
verilog/register_file.sv
verilog/pipeline_walls.sv
verilog/cpu_core.sv
dv/cpu_assertions.sv
dv/cpu_checker.sv
dv/tb_cpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_cpu
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG) || ! grep -q "All tests passed" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
